//--- Bender.yml
package:
  name: serdes_link

sources:
  - hdl/serdes_pkg.sv
  - hdl/prbs_gen.sv
  - hdl/pam4_tx.sv
  - hdl/isi_channel.sv
  - hdl/pam4_rx.sv
  - hdl/prbs_checker.sv
  - hdl/serdes_link.sv
  - target: test
    files:
      - test/serdes_link_tb.sv

//--- hdl/isi_channel.sv
`timescale 1ns/10ps
`default_nettype none

module isi_channel (
    input  wire logic clock,
    input  wire logic reset_n,

    // coefficient stream
    input  wire logic                                  coef_valid,
    output logic                                       coef_ready,
    input  wire logic [serdes_pkg::TAP_IDX_W-1:0]      coef_index,
    input  wire logic signed [serdes_pkg::COEF_W-1:0]  coef_data,
    input  wire logic                                  coef_last,

    // from transmitter
    input  wire logic signed [serdes_pkg::LVL_W-1:0]   tx_level,
    input  wire logic                                  tx_level_valid,
    output logic                                       tx_level_ready,

    // to receiver
    output logic signed [serdes_pkg::LVL_W-1:0]        ch_level,
    output logic                                       ch_level_valid,
    input  wire logic                                  ch_level_ready
);

    serdes_pkg::chan_state_e state;

    logic signed [serdes_pkg::COEF_W-1:0] h [serdes_pkg::NUM_TAPS];
    logic signed [serdes_pkg::LVL_W-1:0]  x1;   // previous sample
    logic signed [serdes_pkg::LVL_W-1:0]  x2;   // two back

    logic signed [serdes_pkg::ACC_W-1:0] acc;
    logic signed [serdes_pkg::ACC_W-1:0] scaled;
    logic signed [serdes_pkg::LVL_W-1:0] sat_level;

    logic coef_xfer;
    logic in_xfer;

    assign coef_ready = (state == serdes_pkg::LOAD_TAPS);
    assign coef_xfer  = coef_valid && coef_ready;

    // no traffic until taps are loaded; hold input while output is stuck
    assign tx_level_ready = (state == serdes_pkg::RUN) && (!ch_level_valid || ch_level_ready);
    assign in_xfer        = tx_level_valid && tx_level_ready;

    // fir sum, all signed
    always_comb begin
        acc    = h[0] * tx_level + h[1] * x1 + h[2] * x2;
        scaled = acc >>> serdes_pkg::COEF_FRAC;   // back to level units

        if (scaled > serdes_pkg::LVL_MAX) begin
            sat_level = serdes_pkg::LVL_W'(serdes_pkg::LVL_MAX);
        end else if (scaled < serdes_pkg::LVL_MIN) begin
            sat_level = serdes_pkg::LVL_W'(serdes_pkg::LVL_MIN);
        end else begin
            sat_level = scaled[serdes_pkg::LVL_W-1:0];
        end
    end

    // tap load fsm
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= serdes_pkg::LOAD_TAPS;
            h[0]  <= serdes_pkg::COEF_W'(serdes_pkg::H0_UNITY);  // identity channel
            h[1]  <= '0;
            h[2]  <= '0;
        end else begin
            case (state)
                serdes_pkg::LOAD_TAPS: begin
                    if (coef_xfer) begin
                        // index 3 has no tap, dropped
                        if (coef_index < serdes_pkg::TAP_IDX_W'(serdes_pkg::NUM_TAPS)) begin
                            h[coef_index] <= coef_data;
                        end
                        if (coef_last) begin
                            state <= serdes_pkg::RUN;
                        end
                    end
                end
                default: state <= serdes_pkg::RUN;   // stays until reset
            endcase
        end
    end

    // history and output register
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            x1             <= '0;   // quiet line before first symbol
            x2             <= '0;
            ch_level_valid <= 1'b0;
        end else begin
            if (in_xfer) begin
                x1             <= tx_level;
                x2             <= x1;
                ch_level_valid <= 1'b1;
            end else if (ch_level_ready) begin
                ch_level_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_xfer) begin
            ch_level <= sat_level;   // one cycle after the input transfer
        end
    end

endmodule

`default_nettype wire

//--- hdl/pam4_rx.sv
`timescale 1ns/10ps
`default_nettype none

module pam4_rx (
    input  wire logic clock,
    input  wire logic reset_n,

    // same coefficient stream the channel sees
    input  wire logic                                  coef_valid,
    input  wire logic                                  coef_ready,
    input  wire logic [serdes_pkg::TAP_IDX_W-1:0]      coef_index,
    input  wire logic signed [serdes_pkg::COEF_W-1:0]  coef_data,
    input  wire logic                                  coef_last,

    input  wire logic signed [serdes_pkg::LVL_W-1:0]   ch_level,
    input  wire logic                                  ch_level_valid,
    output logic                                       ch_level_ready,

    output logic rx_bit,
    output logic rx_bit_valid
);

    serdes_pkg::chan_state_e state;   // tracks whether coefficients are valid

    logic signed [serdes_pkg::COEF_W-1:0] h [serdes_pkg::NUM_TAPS];
    logic signed [serdes_pkg::LVL_W-1:0]  d1;   // last decided level
    logic signed [serdes_pkg::LVL_W-1:0]  d2;

    logic signed [serdes_pkg::ACC_W-1:0] fb_sum;
    logic signed [serdes_pkg::ACC_W-1:0] eq;
    logic signed [serdes_pkg::ACC_W-1:0] thr;
    serdes_pkg::pam4_sym_e sym;

    logic [1:0] bit_sr;     // msb goes out first
    logic [1:0] bits_left;
    logic coef_xfer;
    logic in_xfer;

    assign coef_xfer      = coef_valid && coef_ready;
    assign ch_level_ready = (bits_left == 2'd0);   // busy until both bits sent
    assign in_xfer        = ch_level_valid && ch_level_ready;

    assign rx_bit       = bit_sr[1];
    assign rx_bit_valid = (bits_left != 2'd0);

    // dfe: cancel post-cursors, then slice at -h0 / 0 / +h0
    always_comb begin
        fb_sum = h[1] * d1 + h[2] * d2;
        eq     = ch_level - (fb_sum >>> serdes_pkg::COEF_FRAC);
        thr    = h[0];

        if (eq < -thr) begin
            sym = serdes_pkg::SYM_M3;
        end else if (eq < 0) begin
            sym = serdes_pkg::SYM_M1;
        end else if (eq < thr) begin
            sym = serdes_pkg::SYM_P1;
        end else begin
            sym = serdes_pkg::SYM_P3;
        end
    end

    // local coefficient copy, written on the channel's transfer
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= serdes_pkg::LOAD_TAPS;
            h[0]  <= serdes_pkg::COEF_W'(serdes_pkg::H0_UNITY);
            h[1]  <= '0;
            h[2]  <= '0;
        end else if (state == serdes_pkg::LOAD_TAPS && coef_xfer) begin
            if (coef_index < serdes_pkg::TAP_IDX_W'(serdes_pkg::NUM_TAPS)) begin
                h[coef_index] <= coef_data;
            end
            if (coef_last) begin
                state <= serdes_pkg::RUN;
            end
        end
    end

    // decision history and bit serializer
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            d1        <= '0;   // matches the channel's empty history
            d2        <= '0;
            bit_sr    <= '0;
            bits_left <= '0;
        end else if (in_xfer) begin
            bit_sr    <= serdes_pkg::gray_decode(sym);
            bits_left <= 2'd2;
            if (state == serdes_pkg::RUN) begin
                d1 <= serdes_pkg::sym_level(sym);   // ideal level, not the noisy sample
                d2 <= d1;
            end
        end else if (bits_left != 2'd0) begin
            bit_sr    <= {bit_sr[0], 1'b0};
            bits_left <= bits_left - 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pam4_tx.sv
`timescale 1ns/10ps
`default_nettype none

module pam4_tx (
    input  wire logic clock,
    input  wire logic reset_n,

    input  wire logic tx_bit,
    input  wire logic tx_bit_valid,
    output logic      tx_bit_ready,

    output logic signed [serdes_pkg::LVL_W-1:0] tx_level,
    output logic                                tx_level_valid,
    input  wire logic                           tx_level_ready
);

    logic have_first;    // msb of the pair already taken
    logic first_bit;
    logic bit_xfer;
    logic level_xfer;
    serdes_pkg::pam4_sym_e sym;

    assign tx_bit_ready = !tx_level_valid;   // stall while a level waits
    assign bit_xfer     = tx_bit_valid && tx_bit_ready;
    assign level_xfer   = tx_level_valid && tx_level_ready;

    // pair -> symbol, only meaningful on the second bit
    assign sym = serdes_pkg::gray_encode({first_bit, tx_bit});

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            have_first     <= 1'b0;
            tx_level_valid <= 1'b0;
        end else begin
            if (bit_xfer) begin
                have_first <= !have_first;
            end

            if (bit_xfer && have_first) begin
                tx_level_valid <= 1'b1;     // level out one cycle after second bit
            end else if (level_xfer) begin
                tx_level_valid <= 1'b0;
            end
        end
    end

    // payload regs
    always_ff @(posedge clock) begin
        if (bit_xfer && !have_first) begin
            first_bit <= tx_bit;
        end
        if (bit_xfer && have_first) begin
            tx_level <= serdes_pkg::sym_level(sym);  // held until taken
        end
    end

endmodule

`default_nettype wire

//--- hdl/prbs_checker.sv
`timescale 1ns/10ps
`default_nettype none

module prbs_checker (
    input  wire logic clock,
    input  wire logic reset_n,
    input  wire logic rx_bit,
    input  wire logic rx_bit_valid,   // always accepted
    output logic      locked,
    output logic [serdes_pkg::CNT_W-1:0] error_count,
    output logic [serdes_pkg::CNT_W-1:0] bit_count
);

    logic [serdes_pkg::PRBS_ORDER-1:0] lfsr;
    logic [serdes_pkg::SEED_W-1:0]     seed_cnt;   // bits shifted in before lock
    logic predict;

    assign predict = lfsr[6] ^ lfsr[5];   // same taps as the generator

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            lfsr        <= '0;
            seed_cnt    <= '0;
            locked      <= 1'b0;
            error_count <= '0;
            bit_count   <= '0;
        end else if (rx_bit_valid) begin
            if (!locked) begin
                // self-seed from the line
                lfsr     <= {lfsr[serdes_pkg::PRBS_ORDER-2:0], rx_bit};
                seed_cnt <= seed_cnt + 1'b1;
                if (seed_cnt == serdes_pkg::SEED_W'(serdes_pkg::PRBS_ORDER - 1)) begin
                    locked <= 1'b1;   // seventh bit
                end
            end else begin
                // free-running, so one bad bit gives one error
                lfsr <= {lfsr[serdes_pkg::PRBS_ORDER-2:0], predict};

                if (bit_count != '1) begin
                    bit_count <= bit_count + 1'b1;   // saturating
                end
                if (rx_bit != predict && error_count != '1) begin
                    error_count <= error_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/prbs_gen.sv
`timescale 1ns/10ps
`default_nettype none

module prbs_gen (
    input  wire logic clock,
    input  wire logic reset_n,
    input  wire logic prbs_en,
    input  wire logic inject_error,   // one-cycle pulse
    output logic      tx_bit,
    output logic      tx_bit_valid,
    input  wire logic tx_bit_ready
);

    logic [serdes_pkg::PRBS_ORDER-1:0] lfsr;
    logic feedback;
    logic inj_pending;   // flip the next transferred bit
    logic xfer;

    // x^7 + x^6 + 1
    assign feedback = lfsr[6] ^ lfsr[5];

    // presented bit is the one about to be shifted in, so a checker
    // shifting received bits sees the same state
    assign tx_bit       = feedback ^ inj_pending;
    assign tx_bit_valid = prbs_en;
    assign xfer         = tx_bit_valid && tx_bit_ready;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            lfsr <= '1;   // all-ones seed
        end else if (xfer) begin
            lfsr <= {lfsr[serdes_pkg::PRBS_ORDER-2:0], feedback};  // clean bit, not the flipped one
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            inj_pending <= 1'b0;
        end else if (inject_error) begin
            inj_pending <= 1'b1;   // pulse during a transfer hits the following bit
        end else if (xfer) begin
            inj_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/serdes_link.sv
`timescale 1ns/10ps
`default_nettype none

module serdes_link (
    input  wire logic clock,
    input  wire logic reset_n,

    input  wire logic prbs_en,
    input  wire logic inject_error,

    input  wire logic                                  coef_valid,
    output logic                                       coef_ready,
    input  wire logic [serdes_pkg::TAP_IDX_W-1:0]      coef_index,
    input  wire logic signed [serdes_pkg::COEF_W-1:0]  coef_data,
    input  wire logic                                  coef_last,

    output logic                         locked,
    output logic [serdes_pkg::CNT_W-1:0] error_count,
    output logic [serdes_pkg::CNT_W-1:0] bit_count
);

    // bit stream
    logic tx_bit;
    logic tx_bit_valid;
    logic tx_bit_ready;

    // transmit levels
    logic signed [serdes_pkg::LVL_W-1:0] tx_level;
    logic tx_level_valid;
    logic tx_level_ready;

    // channel output
    logic signed [serdes_pkg::LVL_W-1:0] ch_level;
    logic ch_level_valid;
    logic ch_level_ready;

    // recovered bits
    logic rx_bit;
    logic rx_bit_valid;

    prbs_gen u_prbs_gen (
        .clock        (clock),
        .reset_n      (reset_n),
        .prbs_en      (prbs_en),
        .inject_error (inject_error),
        .tx_bit       (tx_bit),
        .tx_bit_valid (tx_bit_valid),
        .tx_bit_ready (tx_bit_ready)
    );

    pam4_tx u_pam4_tx (
        .clock          (clock),
        .reset_n        (reset_n),
        .tx_bit         (tx_bit),
        .tx_bit_valid   (tx_bit_valid),
        .tx_bit_ready   (tx_bit_ready),
        .tx_level       (tx_level),
        .tx_level_valid (tx_level_valid),
        .tx_level_ready (tx_level_ready)
    );

    // channel owns coef_ready
    isi_channel u_isi_channel (
        .clock          (clock),
        .reset_n        (reset_n),
        .coef_valid     (coef_valid),
        .coef_ready     (coef_ready),
        .coef_index     (coef_index),
        .coef_data      (coef_data),
        .coef_last      (coef_last),
        .tx_level       (tx_level),
        .tx_level_valid (tx_level_valid),
        .tx_level_ready (tx_level_ready),
        .ch_level       (ch_level),
        .ch_level_valid (ch_level_valid),
        .ch_level_ready (ch_level_ready)
    );

    // receiver snoops the same coefficient transfers
    pam4_rx u_pam4_rx (
        .clock          (clock),
        .reset_n        (reset_n),
        .coef_valid     (coef_valid),
        .coef_ready     (coef_ready),
        .coef_index     (coef_index),
        .coef_data      (coef_data),
        .coef_last      (coef_last),
        .ch_level       (ch_level),
        .ch_level_valid (ch_level_valid),
        .ch_level_ready (ch_level_ready),
        .rx_bit         (rx_bit),
        .rx_bit_valid   (rx_bit_valid)
    );

    prbs_checker u_prbs_checker (
        .clock        (clock),
        .reset_n      (reset_n),
        .rx_bit       (rx_bit),
        .rx_bit_valid (rx_bit_valid),
        .locked       (locked),
        .error_count  (error_count),
        .bit_count    (bit_count)
    );

endmodule

`default_nettype wire

//--- hdl/serdes_pkg.sv
`default_nettype none

package serdes_pkg;

    localparam int LVL_W      = 8;   // signed voltage sample
    localparam int COEF_W     = 8;   // signed tap coefficient
    localparam int COEF_FRAC  = 6;   // 64 == unity gain
    localparam int NUM_TAPS   = 3;   // h0 main, h1/h2 post-cursors
    localparam int TAP_IDX_W  = 2;
    localparam int LEVEL_UNIT = 32;  // one level step
    localparam int PRBS_ORDER = 7;   // x^7 + x^6 + 1
    localparam int CNT_W      = 16;

    // derived sizes
    localparam int ACC_W  = LVL_W + COEF_W + 2;     // room for three products
    localparam int SEED_W = $clog2(PRBS_ORDER);     // seed bit counter in checker
    localparam int H0_UNITY = 1 << COEF_FRAC;       // main tap after reset

    localparam int LVL_MAX = (2 ** (LVL_W - 1)) - 1;
    localparam int LVL_MIN = -(2 ** (LVL_W - 1));

    // transmit levels, -96 / -32 / +32 / +96
    localparam logic signed [LVL_W-1:0] LVL_M3 = LVL_W'(-3 * LEVEL_UNIT);
    localparam logic signed [LVL_W-1:0] LVL_M1 = LVL_W'(-1 * LEVEL_UNIT);
    localparam logic signed [LVL_W-1:0] LVL_P1 = LVL_W'(LEVEL_UNIT);
    localparam logic signed [LVL_W-1:0] LVL_P3 = LVL_W'(3 * LEVEL_UNIT);

    typedef enum logic [1:0] {
        SYM_M3 = 2'd0,
        SYM_M1 = 2'd1,
        SYM_P1 = 2'd2,
        SYM_P3 = 2'd3
    } pam4_sym_e;

    typedef enum logic {
        LOAD_TAPS = 1'b0,  // coefficient stream open
        RUN       = 1'b1   // traffic flows
    } chan_state_e;

    // gray map, first bit of the pair is the msb
    function automatic pam4_sym_e gray_encode(input logic [1:0] bits);
        case (bits)
            2'b00:   return SYM_M3;
            2'b01:   return SYM_M1;
            2'b11:   return SYM_P1;
            default: return SYM_P3;
        endcase
    endfunction

    function automatic logic [1:0] gray_decode(input pam4_sym_e sym);
        case (sym)
            SYM_M3:  return 2'b00;
            SYM_M1:  return 2'b01;
            SYM_P1:  return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    function automatic logic signed [LVL_W-1:0] sym_level(input pam4_sym_e sym);
        case (sym)
            SYM_M3:  return LVL_M3;
            SYM_M1:  return LVL_M1;
            SYM_P1:  return LVL_P1;
            default: return LVL_P3;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- test/serdes_link_tb.sv
`timescale 1ns/10ps
`default_nettype none

module serdes_link_tb;

    localparam int WAIT_LIMIT  = 5000;  // cycles allowed per wait loop
    localparam int STALL_BOUND = 4;     // bits allowed to trickle out while stalled

    logic clock;
    logic reset_n;
    logic prbs_en;
    logic inject_error;
    logic coef_valid;
    logic coef_ready;
    logic [serdes_pkg::TAP_IDX_W-1:0]     coef_index;
    logic signed [serdes_pkg::COEF_W-1:0] coef_data;
    logic coef_last;
    logic locked;
    logic [serdes_pkg::CNT_W-1:0] error_count;
    logic [serdes_pkg::CNT_W-1:0] bit_count;

    string test_name;
    int seed;
    int tap1;       // random post-cursors
    int tap2;
    int err_base;
    int bit_base;
    int growth;

    serdes_link DUT (
        .clock        (clock),
        .reset_n      (reset_n),
        .prbs_en      (prbs_en),
        .inject_error (inject_error),
        .coef_valid   (coef_valid),
        .coef_ready   (coef_ready),
        .coef_index   (coef_index),
        .coef_data    (coef_data),
        .coef_last    (coef_last),
        .locked       (locked),
        .error_count  (error_count),
        .bit_count    (bit_count)
    );

    always #2 clock = ~clock;   // 4 ns period

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_eq(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            report_failure($sformatf("ERROR %s %s: expected %0d, actual %0d",
                                     test_name, what, expected, actual));
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset_n      <= 1'b0;
        prbs_en      <= 1'b0;
        inject_error <= 1'b0;
        coef_valid   <= 1'b0;
        coef_last    <= 1'b0;
        repeat (3) @(posedge clock);   // three cycles low
        reset_n <= 1'b1;
    endtask

    // one coefficient transfer, held until the channel takes it
    task automatic write_coef(input int idx, input int data, input bit last);
        int waited;
        waited = 0;
        @(posedge clock);
        coef_valid <= 1'b1;
        coef_index <= serdes_pkg::TAP_IDX_W'(idx);
        coef_data  <= serdes_pkg::COEF_W'(data);
        coef_last  <= last;
        @(negedge clock);
        while (!coef_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) report_failure("coefficient stream never became ready");
            @(negedge clock);
        end
        @(posedge clock);   // transfer happens here
        coef_valid <= 1'b0;
        coef_last  <= 1'b0;
    endtask

    task automatic load_taps(input int h0, input int h1, input int h2);
        write_coef(0, h0, 1'b0);
        write_coef(1, h1, 1'b0);
        write_coef(2, h2, 1'b1);   // last one opens traffic
    endtask

    task automatic wait_locked();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!locked) begin
            waited++;
            if (waited > WAIT_LIMIT) report_failure("checker never locked to the bit stream");
            @(negedge clock);
        end
    endtask

    task automatic wait_bits(input int target);
        int waited;
        waited = 0;
        @(negedge clock);
        while (bit_count < target) begin
            waited++;
            if (waited > WAIT_LIMIT) report_failure("bit count stopped short of its target");
            @(negedge clock);
        end
    endtask

    // counters must sit at zero while unlocked
    always @(negedge clock) begin
        if (reset_n && !locked) begin
            assert (bit_count == 0 && error_count == 0) else begin
                report_failure($sformatf(
                    "ERROR %s counters before lock: expected 0/0, actual %0d/%0d",
                    test_name, bit_count, error_count));
            end
        end
    end

    initial begin
        clock        = 1'b0;
        reset_n      = 1'b0;
        prbs_en      = 1'b0;
        inject_error = 1'b0;
        coef_valid   = 1'b0;
        coef_index   = '0;
        coef_data    = '0;
        coef_last    = 1'b0;

        test_name = "reset_state";
        apply_reset();
        @(negedge clock);
        check_eq("coef_ready", 1, coef_ready);
        check_eq("locked", 0, locked);
        check_eq("error_count", 0, error_count);
        check_eq("bit_count", 0, bit_count);
        @(posedge clock);
        prbs_en <= 1'b1;
        repeat (50) @(negedge clock);   // no taps loaded, nothing flows
        check_eq("bit_count blocked", 0, bit_count);
        check_eq("coef_ready still open", 1, coef_ready);

        test_name = "identity_channel";
        load_taps(64, 0, 0);
        wait_locked();
        wait_bits(200);
        check_eq("error_count", 0, error_count);
        check_eq("coef_ready closed", 0, coef_ready);

        test_name = "isi_dfe";
        apply_reset();
        seed = 32'ha34c;
        tap1 = $random(seed) % 17;   // -16 .. +16
        tap2 = $random(seed) % 17;
        $display("isi taps h0=64 h1=%0d h2=%0d", tap1, tap2);
        @(posedge clock);
        prbs_en <= 1'b1;
        load_taps(64, tap1, tap2);
        wait_locked();
        bit_base = bit_count;
        wait_bits(bit_base + 300);
        check_eq("error_count", 0, error_count);

        test_name = "error_injection";
        err_base = error_count;
        repeat (3) begin
            @(posedge clock);
            inject_error <= 1'b1;    // single-cycle pulse
            @(posedge clock);
            inject_error <= 1'b0;
            repeat (24) @(posedge clock);
        end
        bit_base = bit_count;
        wait_bits(bit_base + 20);    // flush the last flipped bit
        check_eq("error_count", err_base + 3, error_count);

        test_name = "enable_stall";
        @(posedge clock);
        prbs_en <= 1'b0;
        @(negedge clock);
        bit_base = bit_count;   // tx level, channel sample and rx bits may still follow
        repeat (40) begin
            @(negedge clock);
            growth = bit_count - bit_base;
            assert (growth <= STALL_BOUND) else begin
                report_failure($sformatf("ERROR %s bit_count growth: expected <= %0d, actual %0d",
                                         test_name, STALL_BOUND, growth));
            end
        end
        @(posedge clock);
        prbs_en  <= 1'b1;
        err_base = error_count;
        bit_base = bit_count;
        wait_bits(bit_base + 100);
        check_eq("error_count after resume", err_base, error_count);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/serdes_pkg.sv
hdl/prbs_gen.sv
hdl/pam4_tx.sv
hdl/isi_channel.sv
hdl/pam4_rx.sv
hdl/prbs_checker.sv
hdl/serdes_link.sv
test/serdes_link_tb.sv
